//--- logic/mem_geom_pkg.sv
package mem_geom_pkg;

   ////////////////////////////////////////
   // Data path
   ////////////////////////////////////////

   localparam int DATA_W = 32;             // Word width in bits
   localparam int LANES  = DATA_W / 8;     // Byte lanes per word

   ////////////////////////////////////////
   // Addressing
   ////////////////////////////////////////

   // Byte address covers the whole RAM, no range check needed
   localparam int ADDR_W      = 10;
   localparam int OFS_W       = $clog2(LANES);    // Byte offset inside a word
   localparam int WORD_ADDR_W = ADDR_W - OFS_W;   // Word index into the RAM

   // Number of words
   localparam int DEPTH = 256;

endpackage : mem_geom_pkg

//--- logic/mem_access_pkg.sv
package mem_access_pkg;

   import mem_geom_pkg::*;

   ////////////////////////////////////////
   // Opcode
   ////////////////////////////////////////

   // Access width, NONE is handled as a full word
   typedef enum logic [1:0] {
      WIDTH_NONE = 2'd0,
      WIDTH_BYTE = 2'd1,
      WIDTH_HALF = 2'd2,
      WIDTH_WORD = 2'd3
   } mem_width_e;

   typedef struct packed {
      logic       is_signed;   // MSB of the select field
      mem_width_e width;
   } mem_op_t;

   ////////////////////////////////////////
   // Request and response
   ////////////////////////////////////////

   typedef struct packed {
      logic              is_store;
      mem_op_t           op;
      logic [ADDR_W-1:0] addr;       // Byte address
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              is_store;
      logic              misaligned;
      logic [DATA_W-1:0] rdata;      // Zero on stores
   } mem_rsp_t;

endpackage : mem_access_pkg

//--- logic/access_align.sv
module access_align
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  mem_op_t           i_op,
   input  logic [OFS_W-1:0]  i_addr_ofs,
   input  logic [DATA_W-1:0] i_wdata,
   output logic [LANES-1:0]  o_byte_en,
   output logic [DATA_W-1:0] o_wdata_lanes,
   output logic              o_misaligned
);

   ////////////////////////////////////////
   // Misalignment check
   ////////////////////////////////////////

   always_comb
   begin
      case (i_op.width)
         WIDTH_BYTE:
         begin
            o_misaligned = 1'b0;              // Any offset is fine
         end
         WIDTH_HALF:
         begin
            o_misaligned = i_addr_ofs[0];     // Odd byte address
         end
         default:
         begin
            // Word and none need a word boundary
            o_misaligned = |i_addr_ofs;
         end
      endcase
   end

   ////////////////////////////////////////
   // Byte enables
   ////////////////////////////////////////

   always_comb
   begin
      case (i_op.width)
         WIDTH_BYTE:
         begin
            o_byte_en = LANES'(1) << i_addr_ofs;
         end
         WIDTH_HALF:
         begin
            // Low or high pair, offset bit 0 is ignored
            o_byte_en = LANES'(2'b11) << {i_addr_ofs[OFS_W-1], 1'b0};
         end
         default:
         begin
            o_byte_en = '1;
         end
      endcase
   end

   ////////////////////////////////////////
   // Store lane replication
   ////////////////////////////////////////

   // The RAM picks the right copy through the byte enables
   always_comb
   begin
      case (i_op.width)
         WIDTH_BYTE:
         begin
            o_wdata_lanes = {LANES{i_wdata[7:0]}};
         end
         WIDTH_HALF:
         begin
            o_wdata_lanes = {(LANES / 2){i_wdata[15:0]}};
         end
         default:
         begin
            o_wdata_lanes = i_wdata;             // Full word as is
         end
      endcase
   end

endmodule : access_align

//--- logic/data_ram.sv
module data_ram
   import mem_geom_pkg::*;
(
   input  logic                   i_clock,
   input  logic                   i_wr_en,
   input  logic                   i_rd_en,
   input  logic [LANES-1:0]       i_byte_en,
   input  logic [WORD_ADDR_W-1:0] i_word_addr,
   input  logic [DATA_W-1:0]      i_wdata,
   output logic [DATA_W-1:0]      o_rdata
);

   // Word array, contents undefined until written
   logic [DATA_W-1:0] mem [DEPTH];

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (i_wr_en)
      begin
         // Only enabled lanes are touched
         for (int lane = 0; lane < LANES; lane++)
         begin
            if (i_byte_en[lane])
            begin
               mem[i_word_addr][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   // Registered read, holds last word when idle
   always_ff @(posedge i_clock)
   begin
      if (i_rd_en)
      begin
         o_rdata <= mem[i_word_addr];
      end
   end

endmodule : data_ram

//--- logic/load_extract.sv
module load_extract
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  logic [DATA_W-1:0] i_rdata,
   input  mem_op_t           i_op,
   input  logic [OFS_W-1:0]  i_addr_ofs,
   output logic [DATA_W-1:0] o_result
);

   logic [DATA_W-1:0] rdata_shifted;   // Selected part moved to bit 0
   logic              sign_bit;        // Top bit of the kept width

   ////////////////////////////////////////
   // Lane shift
   ////////////////////////////////////////

   always_comb
   begin
      case (i_op.width)
         WIDTH_BYTE:
         begin
            rdata_shifted = i_rdata >> {i_addr_ofs, 3'b000};           // 8 x offset
         end
         WIDTH_HALF:
         begin
            rdata_shifted = i_rdata >> {i_addr_ofs[OFS_W-1], 4'b0000}; // 16 x ofs[1]
         end
         default:
         begin
            rdata_shifted = i_rdata;
         end
      endcase
   end

   ////////////////////////////////////////
   // Sign or zero extension
   ////////////////////////////////////////

   always_comb
   begin
      sign_bit = 1'b0;
      case (i_op.width)
         WIDTH_BYTE:
         begin
            if (i_op.is_signed)
            begin
               sign_bit = rdata_shifted[7];
            end
            o_result = {{(DATA_W - 8){sign_bit}}, rdata_shifted[7:0]};
         end
         WIDTH_HALF:
         begin
            if (i_op.is_signed)
            begin
               sign_bit = rdata_shifted[15];
            end
            o_result = {{(DATA_W - 16){sign_bit}}, rdata_shifted[15:0]};
         end
         default:
         begin
            // Word and none pass through untouched
            o_result = rdata_shifted;
         end
      endcase
   end

endmodule : load_extract

//--- logic/mem_stage.sv
module mem_stage
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
(
   input  logic     i_clock,
   input  logic     i_reset,
   input  logic     i_req_valid,   // One cycle strobe
   input  mem_req_t i_req,
   output logic     o_rsp_valid,   // Two cycles after the strobe
   output mem_rsp_t o_rsp
);

   // Control that rides along with the RAM read
   typedef struct packed {
      logic             is_store;
      mem_op_t          op;
      logic [OFS_W-1:0] addr_ofs;
      logic             misaligned;
   } s2_ctl_t;

   logic                   s1_valid;
   mem_req_t               s1_req;
   logic                   s1_misaligned;
   logic [LANES-1:0]       s1_byte_en;
   logic [DATA_W-1:0]      s1_wdata_lanes;

   logic                   ram_wr_en;
   logic                   ram_rd_en;
   logic [WORD_ADDR_W-1:0] ram_word_addr;
   logic [DATA_W-1:0]      ram_rdata;

   logic                   s2_valid;
   s2_ctl_t                s2_ctl;
   logic [DATA_W-1:0]      load_result;

   ////////////////////////////////////////
   // Stage 1 register
   ////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         s1_valid <= 1'b0;
      end
      else
      begin
         s1_valid <= i_req_valid;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_req_valid)
      begin
         s1_req <= i_req;      // Payload only loads on a strobe
      end
   end

   ////////////////////////////////////////
   // Alignment and RAM access
   ////////////////////////////////////////

   access_align u_access_align (
      .i_op          (s1_req.op),
      .i_addr_ofs    (s1_req.addr[OFS_W-1:0]),
      .i_wdata       (s1_req.wdata),
      .o_byte_en     (s1_byte_en),
      .o_wdata_lanes (s1_wdata_lanes),
      .o_misaligned  (s1_misaligned)
   );

   // Misaligned stores never reach the array
   assign ram_wr_en     = s1_valid & s1_req.is_store & ~s1_misaligned;
   assign ram_rd_en     = s1_valid & ~s1_req.is_store;
   assign ram_word_addr = s1_req.addr[ADDR_W-1:OFS_W];

   data_ram u_data_ram (
      .i_clock     (i_clock),
      .i_wr_en     (ram_wr_en),
      .i_rd_en     (ram_rd_en),
      .i_byte_en   (s1_byte_en),
      .i_word_addr (ram_word_addr),
      .i_wdata     (s1_wdata_lanes),
      .o_rdata     (ram_rdata)
   );

   ////////////////////////////////////////
   // Stage 2 register
   ////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         s2_valid <= 1'b0;
      end
      else
      begin
         s2_valid <= s1_valid;
      end
   end

   // Same edge as the RAM read
   always_ff @(posedge i_clock)
   begin
      s2_ctl.is_store   <= s1_req.is_store;
      s2_ctl.op         <= s1_req.op;
      s2_ctl.addr_ofs   <= s1_req.addr[OFS_W-1:0];
      s2_ctl.misaligned <= s1_misaligned;
   end

   ////////////////////////////////////////
   // Load result and response
   ////////////////////////////////////////

   load_extract u_load_extract (
      .i_rdata    (ram_rdata),
      .i_op       (s2_ctl.op),
      .i_addr_ofs (s2_ctl.addr_ofs),
      .o_result   (load_result)
   );

   assign o_rsp_valid = s2_valid;

   always_comb
   begin
      o_rsp.is_store   = s2_ctl.is_store;
      o_rsp.misaligned = s2_ctl.misaligned;
      o_rsp.rdata      = s2_ctl.is_store ? '0 : load_result;   // Stores return zero
   end

endmodule : mem_stage

//--- verification/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Byte-wide reference image of the data RAM
logic [7:0] ref_mem [0:(1 << ADDR_W) - 1];

// Bytes covered by one access
function automatic int access_bytes(mem_width_e width);
   case (width)
      WIDTH_BYTE: return 1;
      WIDTH_HALF: return 2;
      default:    return 4;     // None acts as a word
   endcase
endfunction

// Natural alignment to the access size
function automatic logic model_misaligned(mem_op_t op, logic [ADDR_W-1:0] addr);
   return (addr & ADDR_W'(access_bytes(op.width) - 1)) != '0;
endfunction

// Misaligned stores leave the image alone
function automatic void model_store(mem_op_t op, logic [ADDR_W-1:0] addr,
                                    logic [DATA_W-1:0] wdata);
   int nbytes;
   nbytes = access_bytes(op.width);
   if (!model_misaligned(op, addr))
   begin
      for (int i = 0; i < nbytes; i++)
      begin
         ref_mem[addr + ADDR_W'(i)] = wdata[8*i +: 8];   // Little endian
      end
   end
endfunction

// Offset bits below the access size are dropped
function automatic logic [DATA_W-1:0] model_load(mem_op_t op, logic [ADDR_W-1:0] addr);
   logic [ADDR_W-1:0] base;
   logic [DATA_W-1:0] value;
   int                nbytes;
   nbytes = access_bytes(op.width);
   base   = addr & ~ADDR_W'(nbytes - 1);
   value  = '0;
   for (int i = 0; i < nbytes; i++)
   begin
      value[8*i +: 8] = ref_mem[base + ADDR_W'(i)];
   end
   if (op.is_signed && nbytes < LANES && value[8*nbytes-1])
   begin
      value = value | ({DATA_W{1'b1}} << (8 * nbytes));   // Sign fill
   end
   return value;
endfunction

// Expected response, applied in strobe order
function automatic mem_rsp_t model_response(mem_req_t r);
   mem_rsp_t rsp;
   rsp.is_store   = r.is_store;
   rsp.misaligned = model_misaligned(r.op, r.addr);
   rsp.rdata      = '0;
   if (r.is_store)
   begin
      model_store(r.op, r.addr, r.wdata);
   end
   else
   begin
      rsp.rdata = model_load(r.op, r.addr);
   end
   return rsp;
endfunction

`endif

//--- verification/tb_mem_stage.sv
module tb_mem_stage
   import mem_geom_pkg::*;
   import mem_access_pkg::*;
();

   localparam int                DRAIN_LIMIT  = 40;
   localparam int                REGION_WORDS = 16;
   localparam logic [ADDR_W-1:0] REGION_BASE  = 10'h140;   // All traffic stays in here

   logic        clock;
   logic        reset;
   logic        req_valid;
   mem_req_t    req;
   logic        rsp_valid;
   mem_rsp_t    rsp;

   logic [31:0] rand_state;
   int          errors = 0;
   int          checks = 0;
   int          cycle_cnt = 0;
   string       cur_test;
   mem_rsp_t    exp_q [$];
   int          strobe_q [$];    // Cycle of each strobe
   mem_rsp_t    exp_rsp;

   `include "tb_mem_model.svh"

   mem_stage u_mem_stage (
      .i_clock     (clock),
      .i_reset     (reset),
      .i_req_valid (req_valid),
      .i_req       (req),
      .o_rsp_valid (rsp_valid),
      .o_rsp       (rsp)
   );

   always #10 clock = ~clock;   // 20-unit period

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
      checks++;
      if (expected !== actual)
      begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Random address in the window, aligned to the width on request
   function automatic logic [ADDR_W-1:0] pick_addr(mem_width_e width, logic aligned);
      logic [1:0] ofs;
      ofs = 2'(next_rand() >> 30);
      if (aligned && width == WIDTH_HALF)
      begin
         ofs[0] = 1'b0;
      end
      else if (aligned && width != WIDTH_BYTE)
      begin
         ofs = 2'b00;
      end
      return REGION_BASE + ADDR_W'((next_rand() >> 28) * 4) + ADDR_W'(ofs);
   endfunction

   task automatic send_req(logic is_store, logic is_signed, mem_width_e width,
                           logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata);
      mem_req_t r;
      r.is_store     = is_store;
      r.op.is_signed = is_signed;
      r.op.width     = width;
      r.addr         = addr;
      r.wdata        = wdata;
      @(posedge clock);
      req_valid <= 1'b1;
      req       <= r;
      exp_q.push_back(model_response(r));
      strobe_q.push_back(cycle_cnt);
   endtask

   task automatic load_region_words();
      for (int w = 0; w < REGION_WORDS; w++)
      begin
         send_req(1'b0, 1'b0, WIDTH_WORD, REGION_BASE + ADDR_W'(4 * w), '0);
      end
   endtask

   // Stop strobing and let the pipe empty
   task automatic finish_phase();
      int waited;
      waited = 0;
      @(posedge clock);
      req_valid <= 1'b0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
      begin
         @(posedge clock);
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("ERROR: %s still waits for %0d responses after %0d cycles",
                  cur_test, exp_q.size(), DRAIN_LIMIT);
         errors++;
         exp_q.delete();
         strobe_q.delete();
      end
   endtask

   ////////////////////////////////////////
   // Response monitor
   ////////////////////////////////////////

   always @(negedge clock)
   begin
      if (!reset && rsp_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("ERROR: %s got a response with no request outstanding", cur_test);
            errors++;
         end
         else
         begin
            exp_rsp = exp_q.pop_front();
            check_value({cur_test, " latency"}, 2, cycle_cnt - strobe_q.pop_front());
            check_value({cur_test, " is_store"}, exp_rsp.is_store, rsp.is_store);
            check_value({cur_test, " misaligned"}, exp_rsp.misaligned, rsp.misaligned);
            check_value({cur_test, " rdata"}, exp_rsp.rdata, rsp.rdata);
         end
      end
      cycle_cnt++;
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial
   begin
      logic [31:0]       r;
      mem_width_e        width;
      logic [ADDR_W-1:0] addr;
      int                count;
      clock      = 1'b0;
      reset      = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      rand_state = 32'hde860366;
      cur_test   = "reset";
      repeat (2) @(posedge clock);
      reset <= 1'b0;

      for (int i = 0; i < 8; i++)
      begin
         @(negedge clock);
         check_value("reset_idle", 1'b0, rsp_valid);   // No strobe so no response
      end

      cur_test = "word_fill";
      for (int w = 0; w < REGION_WORDS; w++)
      begin
         send_req(1'b1, 1'b0, WIDTH_WORD, REGION_BASE + ADDR_W'(4 * w), next_rand());
      end
      load_region_words();
      finish_phase();

      cur_test = "byte_half_store";
      for (int i = 0; i < 24; i++)
      begin
         r     = next_rand();
         width = r[31] ? WIDTH_HALF : WIDTH_BYTE;
         addr  = pick_addr(width, 1'b1);
         send_req(1'b1, 1'b0, width, addr, next_rand());
      end
      load_region_words();
      finish_phase();

      cur_test = "sub_word_load";
      for (int i = 0; i < 40; i++)
      begin
         r     = next_rand();
         width = r[31] ? WIDTH_HALF : WIDTH_BYTE;
         send_req(1'b0, r[30], width, pick_addr(width, 1'b1), '0);
      end
      finish_phase();

      cur_test = "misaligned";
      for (int i = 0; i < 24; i++)
      begin
         r     = next_rand();
         width = r[31] ? WIDTH_HALF : (r[29] ? WIDTH_WORD : WIDTH_NONE);   // Word or none
         addr  = pick_addr(width, 1'b1);
         if (width == WIDTH_HALF)
         begin
            addr = addr | ADDR_W'(1);
         end
         else
         begin
            addr = addr + ADDR_W'((r[28:27] == 2'b00) ? 2'd2 : r[28:27]);
         end
         send_req(r[30], r[26], width, addr, next_rand());
      end
      load_region_words();   // Stores above must not show here
      finish_phase();

      cur_test = "random_mix";
      count = 0;
      while (count < 300)
      begin
         r     = next_rand();
         width = mem_width_e'(r[31:30]);
         addr  = pick_addr(width, r[29] | r[28]);   // Mostly aligned
         send_req(r[27] | r[26], r[25], width, addr, next_rand());
         count++;
         if (r[27] && count < 300)
         begin
            // Same word read right behind the store
            width = mem_width_e'(r[24:23]);
            send_req(1'b0, r[22], width, {addr[ADDR_W-1:2], 2'(next_rand() >> 30)}, '0);
            count++;
         end
      end
      finish_phase();

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule : tb_mem_stage

//--- sim.f
+incdir+verification
logic/mem_geom_pkg.sv
logic/mem_access_pkg.sv
logic/access_align.sv
logic/data_ram.sv
logic/load_extract.sv
logic/mem_stage.sv
verification/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  # Packages first, then the blocks, then the top level
  - logic/mem_geom_pkg.sv
  - logic/mem_access_pkg.sv
  - logic/access_align.sv
  - logic/data_ram.sv
  - logic/load_extract.sv
  - logic/mem_stage.sv

  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_mem_stage.sv
